// File: filelist.f
logic/audio_pkg.sv
logic/hps_cmd_decoder.sv
logic/audio_mix_channel.sv
logic/audio_sd_dac.sv
logic/sys_audio_top.sv
verification/sys_audio_assertions.sv
verification/tb_sys_audio.sv

// File: Makefile
SRCS := $(wildcard logic/*.sv verification/*.sv)

all: run

obj_dir/Vtb_sys_audio: $(SRCS) filelist.f
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_sys_audio -f filelist.f -Mdir obj_dir

run: obj_dir/Vtb_sys_audio
	@out="$$(./obj_dir/Vtb_sys_audio)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: verification/tb_sys_audio.sv
// Drives host writes and stereo samples into sys_audio_top; expects a stereo build with N_CH of 2
`timescale 1ns/1ns

module tb_sys_audio;
	import audio_pkg::*;

	logic        clk;
	logic        resetd;
	logic [15:0] i_io_din;
	logic        i_io_clk;
	logic        i_io_uio;
	logic [7:0]  i_led_core;
	logic [1:0]  i_audio_mix;
	logic        i_audio_signed;
	logic [15:0] i_core_l;
	logic [15:0] i_core_r;
	logic [15:0] i_linux_l;
	logic [15:0] i_linux_r;
	logic        o_io_ack;
	logic [7:0]  o_led;
	logic [15:0] o_audio_l;
	logic [15:0] o_audio_r;
	logic        o_dac_l;
	logic        o_dac_r;

	// Model of the decoder registers
	logic [4:0]  att_q;
	logic [7:0]  led_ov;
	logic [7:0]  led_st;
	logic [31:0] exp_pair;
	logic        cmp_en;
	logic [31:0] lfsr_q;
	logic [31:0] r;
	logic [15:0] ob;
	int          cnt_l;
	int          cnt_r;
	int          ones_l;
	int          ones_r;

	sys_audio_top u_sys_audio_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	// Each LED shows the host state bit where overtake is set
	function automatic logic [7:0] led_expect(input logic [7:0] ov, input logic [7:0] st,
		input logic [7:0] core);
		logic [7:0] e;
		for (int b = 0; b < 8; b++)
			e[b] = ov[b] ? st[b] : core[b];
		return e;
	endfunction

	// Expected {right, left} from the mixing rules
	function automatic logic [31:0] ref_mix(input logic [15:0] cl, input logic [15:0] cr,
		input logic [15:0] ll, input logic [15:0] lr, input logic [1:0] mix,
		input logic sgn, input logic [4:0] att);
		logic [15:0] c [2];
		logic [15:0] l [2];
		int          s [2];
		int          p;
		int          y;
		logic [31:0] res;
		c[0] = cl;
		c[1] = cr;
		l[0] = ll;
		l[1] = lr;
		for (int i = 0; i < 2; i++) begin
			y = sgn ? int'($signed(c[i])) : int'(c[i] >> 1);
			s[i] = y + int'($signed(l[i]));
		end
		for (int i = 0; i < 2; i++) begin
			p = s[(i + 1) % 2] >>> 1;
			case (mix)
				2'd0: y = s[i];
				2'd1: y = s[i] - (s[i] >>> 3) + (p >>> 2);
				2'd2: y = s[i] - (s[i] >>> 2) + (p >>> 1);
				default: y = (s[i] >>> 1) + p;
			endcase
			y = att[4] ? 0 : (y >>> att[3:0]);
			if (y > 32767)
				y = 32767;
			else if (y < -32768)
				y = -32768;
			res[16*i +: 16] = y[15:0];
		end
		return res;
	endfunction

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (o_io_ack !== level) begin
			step(1);
			n++;
			if (n > 40) begin
				$display("Timeout: o_io_ack never reached %0b after the host strobe", level);
				$display("TEST FAIL");
				$fatal(1, "acknowledge wait expired");
			end
		end
	endtask

	// Only the rising strobe carries the word
	task automatic host_write(input logic [15:0] word);
		i_io_din = word;
		step(1);
		i_io_clk = 1'b1;
		wait_ack(1'b1);
		i_io_clk = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic send_cmd(input logic [7:0] code, input logic [15:0] data);
		i_io_uio = 1'b1;
		step(2);
		host_write({8'h00, code});
		host_write(data);
		i_io_uio = 1'b0;
		step(4);
	endtask

	task automatic compare_now();
		exp_pair = ref_mix(i_core_l, i_core_r, i_linux_l, i_linux_r,
			i_audio_mix, i_audio_signed, att_q);
		cmp_en = 1'b1;
		step(2);
		cmp_en = 1'b0;
	endtask

	task automatic apply_and_check(input logic [15:0] cl, input logic [15:0] cr,
		input logic [15:0] ll, input logic [15:0] lr, input logic [1:0] mix, input logic sgn);
		i_core_l = cl;
		i_core_r = cr;
		i_linux_l = ll;
		i_linux_r = lr;
		i_audio_mix = mix;
		i_audio_signed = sgn;
		step(20);
		compare_now();
	endtask

	task automatic apply_random(input logic [1:0] mix, input logic sgn);
		logic [31:0] a;
		logic [31:0] b;
		rand_bits(32, a);
		rand_bits(32, b);
		apply_and_check(a[15:0], a[31:16], b[15:0], b[31:16], mix, sgn);
	endtask

	// Compare process, sampling mid-cycle
	always @(negedge clk) begin
		if (cmp_en) begin
			check("o_audio_l", {16'h0, o_audio_l}, {16'h0, exp_pair[15:0]});
			check("o_audio_r", {16'h0, o_audio_r}, {16'h0, exp_pair[31:16]});
			check("o_led", {24'h0, o_led}, {24'h0, led_expect(led_ov, led_st, i_led_core)});
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		resetd = 1'b1;
		i_io_din = '0;
		i_io_clk = 1'b0;
		i_io_uio = 1'b0;
		i_led_core = 8'h5a;
		i_audio_mix = 2'd0;
		i_audio_signed = 1'b0;
		i_core_l = '0;
		i_core_r = '0;
		i_linux_l = '0;
		i_linux_r = '0;
		att_q = '0;
		led_ov = '0;
		led_st = '0;
		exp_pair = '0;
		cmp_en = 1'b0;
		lfsr_q = 32'h6b92;
		repeat (3) @(posedge clk);
		#1;
		resetd = 1'b0;
		@(negedge clk);
		check("o_io_ack", {31'h0, o_io_ack}, 32'h0);
		check("o_dac_l", {31'h0, o_dac_l}, 32'h0);
		check("o_dac_r", {31'h0, o_dac_r}, 32'h0);
		step(1);
		compare_now();

		// LED overtake over several core patterns
		for (int w = 0; w < 3; w++) begin
			rand_bits(16, r);
			send_cmd(CMD_LED, r[15:0]);
			led_ov = r[15:8];
			led_st = r[7:0];
			for (int k = 0; k < 4; k++) begin
				rand_bits(8, r);
				i_led_core = r[7:0];
				step(1);
				compare_now();
			end
		end

		// Every shift plus mute, no cross-feed
		for (int a = 0; a <= 16; a++) begin
			send_cmd(CMD_VOL, {11'h0, 5'(a)});
			att_q = 5'(a);
			apply_random(2'd0, 1'b1);
			apply_random(2'd0, 1'b0);
		end

		send_cmd(CMD_VOL, 16'h0001);
		att_q = 5'd1;
		for (int m = 1; m < 4; m++) begin
			for (int k = 0; k < 4; k++) begin
				rand_bits(1, r);
				apply_random(2'(m), r[0]);
			end
		end

		// Saturation both ways
		send_cmd(CMD_VOL, 16'h0000);
		att_q = 5'd0;
		apply_and_check(16'h7fff, 16'h7000, 16'h7fff, 16'h7800, 2'd0, 1'b1);
		check("o_audio_l", {16'h0, o_audio_l}, 32'h7fff);
		check("o_audio_r", {16'h0, o_audio_r}, 32'h7fff);
		apply_and_check(16'h8000, 16'h9000, 16'h8000, 16'h8800, 2'd0, 1'b1);
		check("o_audio_l", {16'h0, o_audio_l}, 32'h8000);
		check("o_audio_r", {16'h0, o_audio_r}, 32'h8000);

		////////////////////////////////////////
		// DAC density
		////////////////////////////////////////

		apply_and_check(16'h2000, 16'he000, 16'h0000, 16'h0000, 2'd0, 1'b1);
		cnt_l = 0;
		cnt_r = 0;
		repeat (4096) begin
			step(1);
			if (o_dac_l)
				cnt_l++;
			if (o_dac_r)
				cnt_r++;
		end
		ob = exp_pair[15:0] ^ 16'h8000;
		ones_l = int'(ob) * 4096 / 65536;
		ob = exp_pair[31:16] ^ 16'h8000;
		ones_r = int'(ob) * 4096 / 65536;
		// One count of slack for the starting accumulator
		if (cnt_l >= ones_l - 1 && cnt_l <= ones_l + 1)
			cnt_l = ones_l;
		if (cnt_r >= ones_r - 1 && cnt_r <= ones_r + 1)
			cnt_r = ones_r;
		check("o_dac_l ones", cnt_l, ones_l);
		check("o_dac_r ones", cnt_r, ones_r);

		if (u_sys_audio_top.u_hps_cmd_decoder.u_sys_audio_assertions.fail_cnt != 0) begin
			$display("Host port protocol assertions failed during the run");
			$display("TEST FAIL");
			$fatal(1, "protocol assertion failure");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// File: verification/sys_audio_assertions.sv
// Bound into every hps_cmd_decoder instance; checks assume the host waits for the acknowledge
`timescale 1ns/1ns

module sys_audio_assertions
	import audio_pkg::*;
(
	input logic             clk,
	input logic             resetd,
	input logic             io_clk,
	input logic             strobe,
	input logic             o_io_ack,
	input logic [ATT_W-1:0] o_vol_att
);

	// Count of failed assertions
	int fail_cnt = 0;

	// Ack rises two cycles after the strobe, through rack
	ack_rise_after_strobe: assert property (@(posedge clk) disable iff (resetd)
		$rose(o_io_ack) |-> $past(strobe, 2))
		else begin
			$error("acknowledge rose without a preceding strobe");
			fail_cnt++;
		end

	// Settled handshake holds the acknowledge
	ack_quiet_when_agreed: assert property (@(posedge clk) disable iff (resetd)
		(io_clk == o_io_ack) && $stable(io_clk) |=> $stable(o_io_ack))
		else begin
			$error("acknowledge moved while it already matched the host strobe");
			fail_cnt++;
		end

	// Volume register loads in the cycle after the strobe
	vol_load_after_strobe: assert property (@(posedge clk) disable iff (resetd)
		!$stable(o_vol_att) |-> $past(strobe, 2))
		else begin
			$error("volume changed without a host strobe");
			fail_cnt++;
		end

endmodule

bind hps_cmd_decoder sys_audio_assertions u_sys_audio_assertions (
	.clk      (clk),
	.resetd   (resetd),
	.io_clk   (io_clk),
	.strobe   (strobe),
	.o_io_ack (o_io_ack),
	.o_vol_att(o_vol_att)
);

// File: logic/sys_audio_top.sv
// Single clock domain; stereo only, channel 0 is left and channel 1 is right
`timescale 1ns/1ns

module sys_audio_top
	import audio_pkg::*;
(
	input  logic                clk,
	input  logic                resetd,
	input  logic [HOST_W-1:0]   i_io_din,
	input  logic                i_io_clk,
	input  logic                i_io_uio,
	input  logic [7:0]          i_led_core,
	input  logic [MIX_W-1:0]    i_audio_mix,
	input  logic                i_audio_signed,
	input  logic [SAMPLE_W-1:0] i_core_l,
	input  logic [SAMPLE_W-1:0] i_core_r,
	input  logic [SAMPLE_W-1:0] i_linux_l,
	input  logic [SAMPLE_W-1:0] i_linux_r,
	output logic                o_io_ack,
	output logic [7:0]          o_led,
	output logic [SAMPLE_W-1:0] o_audio_l,
	output logic [SAMPLE_W-1:0] o_audio_r,
	output logic                o_dac_l,
	output logic                o_dac_r
);

	localparam int N_CH = 2;

	logic [ATT_W-1:0]              vol_att;
	logic [N_CH-1:0][SAMPLE_W-1:0] core_s;
	logic [N_CH-1:0][SAMPLE_W-1:0] linux_s;
	logic [N_CH-1:0][SAMPLE_W-1:0] pre_s;
	logic [N_CH-1:0][SAMPLE_W-1:0] mix_s;
	logic [N_CH-1:0]               dac_s;

	assign core_s  = {i_core_r, i_core_l};
	assign linux_s = {i_linux_r, i_linux_l};

	hps_cmd_decoder u_hps_cmd_decoder (
		.clk       (clk),
		.resetd    (resetd),
		.i_io_din  (i_io_din),
		.i_io_clk  (i_io_clk),
		.i_io_uio  (i_io_uio),
		.i_led_core(i_led_core),
		.o_io_ack  (o_io_ack),
		.o_vol_att (vol_att),
		.o_led     (o_led)
	);

	// Each channel takes its cross-feed from the next one
	for (genvar i = 0; i < N_CH; i++) begin : g_mix
		audio_mix_channel u_mix (
			.clk      (clk),
			.resetd   (resetd),
			.i_core   (core_s[i]),
			.i_linux  (linux_s[i]),
			.i_pre    (pre_s[(i + 1) % N_CH]),
			.i_mix    (i_audio_mix),
			.i_signed (i_audio_signed),
			.i_vol_att(vol_att),
			.o_pre    (pre_s[i]),
			.o_sample (mix_s[i])
		);
	end

	audio_sd_dac #(.N_CH(N_CH)) u_audio_sd_dac (
		.clk     (clk),
		.resetd  (resetd),
		.i_sample(mix_s),
		.o_dac   (dac_s)
	);

	assign o_audio_l = mix_s[0];
	assign o_audio_r = mix_s[1];
	assign o_dac_l   = dac_s[0];
	assign o_dac_r   = dac_s[1];

endmodule

// File: logic/audio_sd_dac.sv
// First-order sigma-delta only; the one-bit outputs need an external RC low-pass filter
`timescale 1ns/1ns

module audio_sd_dac
	import audio_pkg::*;
#(
	parameter int N_CH = 2
)
(
	input  logic                          clk,
	input  logic                          resetd,
	input  logic [N_CH-1:0][SAMPLE_W-1:0] i_sample,
	output logic [N_CH-1:0]               o_dac
);

	logic [N_CH-1:0][SAMPLE_W-1:0] acc;
	logic [N_CH-1:0][SAMPLE_W:0]   sum;

	// Offset-binary sample added to each accumulator
	always_comb begin
		for (int ch = 0; ch < N_CH; ch++) begin
			sum[ch] = {1'b0, acc[ch]}
				+ {1'b0, ~i_sample[ch][SAMPLE_W-1], i_sample[ch][SAMPLE_W-2:0]};
		end
	end

	// Carry out is the DAC bit
	always_ff @(posedge clk) begin
		if (resetd) begin
			acc   <= '0;
			o_dac <= '0;
		end else begin
			for (int ch = 0; ch < N_CH; ch++) begin
				acc[ch]   <= sum[ch][SAMPLE_W-1:0];
				o_dac[ch] <= sum[ch][SAMPLE_W];
			end
		end
	end

endmodule

// File: logic/audio_mix_channel.sv
// Nine-cycle pipeline from core sample to output; i_pre must come from the partner channel's o_pre
`timescale 1ns/1ns

module audio_mix_channel
	import audio_pkg::*;
(
	input  logic                clk,
	input  logic                resetd,
	input  logic [SAMPLE_W-1:0] i_core,
	input  logic [SAMPLE_W-1:0] i_linux,
	input  logic [SAMPLE_W-1:0] i_pre,
	input  logic [MIX_W-1:0]    i_mix,
	input  logic                i_signed,
	input  logic [ATT_W-1:0]    i_vol_att,
	output logic [SAMPLE_W-1:0] o_pre,
	output logic [SAMPLE_W-1:0] o_sample
);

	logic [SAMPLE_W-1:0] d1, d2, d3;
	logic [SAMPLE_W-1:0] ca;
	logic signed [SAMPLE_W:0] a1, a2, a3, a4;
	logic signed [SAMPLE_W:0] pre_x;

	////////////////////////////////////////
	// Glitch filter
	////////////////////////////////////////

	// Sample is taken once two taps agree
	always_ff @(posedge clk) begin
		if (resetd) begin
			d1 <= '0;
			d2 <= '0;
			d3 <= '0;
			ca <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			if (d2 == d3)
				ca <= d2;
		end
	end

	assign pre_x = {i_pre[SAMPLE_W-1], i_pre};

	////////////////////////////////////////
	// Sum, cross-feed, attenuate, clamp
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1       <= '0;
			a2       <= '0;
			a3       <= '0;
			a4       <= '0;
			o_pre    <= '0;
			o_sample <= '0;
		end else begin
			// Unsigned core audio is halved to fit the signed range
			a1 <= i_signed ? {ca[SAMPLE_W-1], ca} : {2'b00, ca[SAMPLE_W-1:1]};
			a2 <= a1 + {i_linux[SAMPLE_W-1], i_linux};
			o_pre <= a2[SAMPLE_W:1];
			case (i_mix)
				2'd0: a3 <= a2;
				2'd1: a3 <= a2 - (a2 >>> 3) + (pre_x >>> 2);
				2'd2: a3 <= a2 - (a2 >>> 2) + (pre_x >>> 1);
				default: a3 <= (a2 >>> 1) + pre_x;
			endcase
			if (i_vol_att[ATT_W-1])
				a4 <= '0;
			else
				a4 <= a3 >>> i_vol_att[ATT_W-2:0];
			// Saturate when the two top bits disagree
			if (a4[SAMPLE_W] ^ a4[SAMPLE_W-1])
				o_sample <= {a4[SAMPLE_W], {(SAMPLE_W-1){a4[SAMPLE_W-1]}}};
			else
				o_sample <= a4[SAMPLE_W-1:0];
		end
	end

endmodule

// File: logic/hps_cmd_decoder.sv
// Host must hold i_io_din until o_io_ack matches i_io_clk; no wait states, only rising strobes carry words
`timescale 1ns/1ns

module hps_cmd_decoder
	import audio_pkg::*;
(
	input  logic             clk,
	input  logic             resetd,
	input  hps_word_u        i_io_din,
	input  logic             i_io_clk,
	input  logic             i_io_uio,
	input  logic [7:0]       i_led_core,
	output logic             o_io_ack,
	output logic [ATT_W-1:0] o_vol_att,
	output logic [7:0]       o_led
);

	hps_word_u  din_m;
	hps_word_u  din_s;
	logic [1:0] clk_sync;
	logic [1:0] uio_sync;
	logic       io_clk;
	logic       io_uio;
	logic       rack;
	logic       strobe;
	logic       strobe_d;
	logic       has_cmd;
	logic [7:0] cmd;
	logic [7:0] led_overtake;
	logic [7:0] led_state;

	////////////////////////////////////////
	// Host port synchronizers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		din_m <= i_io_din;
		din_s <= din_m;
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			clk_sync <= '0;
			uio_sync <= '0;
		end else begin
			clk_sync <= {clk_sync[0], i_io_clk};
			uio_sync <= {uio_sync[0], i_io_uio};
		end
	end

	assign io_clk = clk_sync[1];
	assign io_uio = uio_sync[1];

	// One-cycle pulse on each rising host strobe
	assign strobe = io_clk & ~rack;

	always_ff @(posedge clk) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
			strobe_d <= 1'b0;
		end else begin
			rack     <= io_clk;
			o_io_ack <= rack;
			strobe_d <= strobe;
		end
	end

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////

	// First word after select is the command, the rest is its data
	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd      <= 1'b0;
			cmd          <= '0;
			led_overtake <= '0;
			led_state    <= '0;
			o_vol_att    <= '0;
		end else if (!io_uio) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (strobe_d) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= din_s.cmd.code;
			end else begin
				case (cmd)
					CMD_LED: begin
						led_overtake <= din_s.led.overtake;
						led_state    <= din_s.led.state;
					end
					CMD_VOL: o_vol_att <= din_s.raw[ATT_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// Host state wins where overtake is set
	assign o_led = (led_overtake & led_state) | (~led_overtake & i_led_core);

endmodule

// File: logic/audio_pkg.sv
// Shared audio and host port definitions; widths are fixed at 16-bit samples and 16-bit host words
package audio_pkg;

	////////////////////////////////////////
	// Data path widths
	////////////////////////////////////////

	localparam int SAMPLE_W = 16;
	localparam int HOST_W   = 16;

	// Top bit mutes, low four bits give the right shift
	localparam int ATT_W    = 5;
	localparam int MIX_W    = 2;

	////////////////////////////////////////
	// Host command codes
	////////////////////////////////////////

	localparam logic [7:0] CMD_LED = 8'h25;
	localparam logic [7:0] CMD_VOL = 8'h26;

	// One host word, read as a command byte or as LED data
	typedef union packed {
		logic [HOST_W-1:0] raw;
		struct packed {
			logic [7:0] pad;
			logic [7:0] code;
		} cmd;
		struct packed {
			logic [7:0] overtake;
			logic [7:0] state;
		} led;
	} hps_word_u;

endpackage
